// File: Makefile
# Verilator build and run for the misc double FPU

VERILATOR ?= verilator
TOP       ?= tb_fpu_misc
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 22881
TIMEOUT   ?= 200
PASS_TEXT := Everything OK

VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG SEED TIMEOUT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) \
		-GSEED=$(SEED) -GTIMEOUT=$(TIMEOUT) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "FAIL: pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/fp_compare.sv
`timescale 1ns/10ps
// compare and min/max logic of the misc FPU
// fle, flt, feq, fmin, fmax with NaN and signed zero rules

module fp_compare (
	input  fpu_misc_pkg::fp_op_e    op,
	input  logic [63:0]             opa,
	input  logic [63:0]             opb,
	input  fpu_misc_pkg::fp_class_t cls_a,
	input  fpu_misc_pkg::fp_class_t cls_b,
	output logic [63:0]             result,
	output fpu_misc_pkg::fp_flags_t flags
);

	logic a_nan;
	logic b_nan;
	logic any_nan;
	logic any_snan;
	logic both_zero; // +0 and -0 compare equal
	logic mag_lt;
	logic mag_gt;
	logic lt_tot;    // total order, -0 below +0
	logic lt;
	logic eq;

	assign a_nan     = cls_a.snan || cls_a.qnan;
	assign b_nan     = cls_b.snan || cls_b.qnan;
	assign any_nan   = a_nan || b_nan;
	assign any_snan  = cls_a.snan || cls_b.snan;
	assign both_zero = cls_a.zero && cls_b.zero;

	assign mag_lt = opa[62:0] < opb[62:0];
	assign mag_gt = opa[62:0] > opb[62:0];

	// negative values order by falling magnitude
	assign lt_tot = (cls_a.sign != cls_b.sign) ? cls_a.sign : (cls_a.sign ? mag_gt : mag_lt);
	assign lt     = lt_tot && !both_zero;
	assign eq     = (opa == opb) || both_zero;

	always_comb
	begin
		result = '0;
		flags  = '0;
		case (op)
			fpu_misc_pkg::OP_FLE:
			begin
				result[0]     = !any_nan && (lt || eq);
				flags.invalid = any_nan; // signalling compare
			end
			fpu_misc_pkg::OP_FLT:
			begin
				result[0]     = !any_nan && lt;
				flags.invalid = any_nan;
			end
			fpu_misc_pkg::OP_FEQ:
			begin
				result[0]     = !any_nan && eq;
				flags.invalid = any_snan; // quiet compare
			end
			fpu_misc_pkg::OP_FMIN,
			fpu_misc_pkg::OP_FMAX:
			begin
				flags.invalid = any_snan;
				if (a_nan && b_nan)
					result = fpu_misc_pkg::CANON_NAN_D;
				else if (a_nan)
					result = opb; // a lone NaN loses
				else if (b_nan)
					result = opa;
				else if (lt_tot == (op == fpu_misc_pkg::OP_FMIN))
					result = opa;
				else
					result = opb;
			end
			default: ;
		endcase
	end

endmodule

// File: logic/fp_execute.sv
`timescale 1ns/10ps
// stage 2 of the misc FPU pipeline
// result select by opcode, output registers and handshake

module fp_execute (
	input  logic                    clk,
	input  logic                    rst,
	fp_stage_if.consumer            stage,
	output logic                    out_valid,
	input  logic                    out_ready,
	output logic [63:0]             result,
	output fpu_misc_pkg::fp_flags_t flags
);

	logic [63:0]             cmp_result;
	logic [63:0]             fmt_result;
	logic [63:0]             sel_result;
	fpu_misc_pkg::fp_flags_t cmp_flags;
	fpu_misc_pkg::fp_flags_t fmt_flags;
	fpu_misc_pkg::fp_flags_t sel_flags;
	logic                    use_cmp;

	fp_compare i_compare (
		.op     (stage.op),
		.opa    (stage.opa),
		.opb    (stage.opb),
		.cls_a  (stage.cls_a),
		.cls_b  (stage.cls_b),
		.result (cmp_result),
		.flags  (cmp_flags)
	);

	fp_format i_format (
		.op     (stage.op),
		.opa    (stage.opa),
		.opb    (stage.opb),
		.cls_a  (stage.cls_a),
		.result (fmt_result),
		.flags  (fmt_flags)
	);

	always_comb
	begin
		case (stage.op)
			fpu_misc_pkg::OP_FLE,
			fpu_misc_pkg::OP_FLT,
			fpu_misc_pkg::OP_FEQ,
			fpu_misc_pkg::OP_FMIN,
			fpu_misc_pkg::OP_FMAX: use_cmp = 1'b1;
			default:               use_cmp = 1'b0;
		endcase
	end

	assign sel_result  = use_cmp ? cmp_result : fmt_result;
	assign sel_flags   = use_cmp ? cmp_flags : fmt_flags;
	assign stage.ready = !out_valid || out_ready; // empty or draining

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			flags     <= '0;
		end
		else if (stage.ready)
		begin
			out_valid <= stage.valid;
			if (stage.valid)
				flags <= sel_flags;
		end
	end

	always_ff @(posedge clk)
	begin
		if (stage.valid && stage.ready)
			result <= sel_result;
	end

	// held output under back-pressure
	out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(result) && $stable(flags));

endmodule

// File: logic/fp_format.sv
`timescale 1ns/10ps
// sign injection, fclass mask and single/double conversions
// of the misc FPU, all combinational

module fp_format (
	input  fpu_misc_pkg::fp_op_e    op,
	input  logic [63:0]             opa,
	input  logic [63:0]             opb,
	input  fpu_misc_pkg::fp_class_t cls_a,
	output logic [63:0]             result,
	output fpu_misc_pkg::fp_flags_t flags
);

	logic [fpu_misc_pkg::SGL_EXP_W-1:0]  s_exp;    // single operand in opa[31:0]
	logic [fpu_misc_pkg::SGL_FRAC_W-1:0] s_frac;
	logic [10:0]                         d_exp;    // widened single exponent
	logic [fpu_misc_pkg::SGL_FRAC_W:0]   frac_rnd; // top bit is the carry
	logic signed [12:0]                  sgl_exp;
	fpu_misc_pkg::class_bit_e            cls_idx;

	//////////////////////////////
	// single to double
	//////////////////////////////

	assign s_exp  = opa[fpu_misc_pkg::SGL_FRAC_W +: fpu_misc_pkg::SGL_EXP_W];
	assign s_frac = opa[fpu_misc_pkg::SGL_FRAC_W-1:0];
	assign d_exp  = 11'(s_exp) + 11'(fpu_misc_pkg::BIAS_DIFF);

	//////////////////////////////
	// double to single
	//////////////////////////////

	// round half up on bit 28
	assign frac_rnd = {1'b0, opa[51:29]} + {23'b0, opa[28]};
	assign sgl_exp  = 13'(opa[62:52]) - 13'(fpu_misc_pkg::BIAS_DIFF) + 13'(frac_rnd[23]);

	// fclass bit for opa
	always_comb
	begin
		if (cls_a.snan)
			cls_idx = fpu_misc_pkg::CLS_SNAN;
		else if (cls_a.qnan)
			cls_idx = fpu_misc_pkg::CLS_QNAN;
		else if (cls_a.inf)
			cls_idx = cls_a.sign ? fpu_misc_pkg::CLS_NEG_INF : fpu_misc_pkg::CLS_POS_INF;
		else if (cls_a.normal)
			cls_idx = cls_a.sign ? fpu_misc_pkg::CLS_NEG_NORM : fpu_misc_pkg::CLS_POS_NORM;
		else if (cls_a.subnormal)
			cls_idx = cls_a.sign ? fpu_misc_pkg::CLS_NEG_SUB : fpu_misc_pkg::CLS_POS_SUB;
		else
			cls_idx = cls_a.sign ? fpu_misc_pkg::CLS_NEG_ZERO : fpu_misc_pkg::CLS_POS_ZERO;
	end

	always_comb
	begin
		result = '0;
		flags  = '0;
		case (op)
			fpu_misc_pkg::OP_SGNJ:  result = {opb[63], opa[62:0]};
			fpu_misc_pkg::OP_SGNJN: result = {~opb[63], opa[62:0]};
			fpu_misc_pkg::OP_SGNJX: result = {opa[63] ^ opb[63], opa[62:0]};
			fpu_misc_pkg::OP_CLASS: result = 64'd1 << cls_idx;
			fpu_misc_pkg::OP_CVT_D_S:
			begin
				if (&s_exp && |s_frac)
				begin
					result        = fpu_misc_pkg::CANON_NAN_D;
					flags.invalid = !s_frac[22];
				end
				else if (&s_exp)
					result = {opa[31], 11'h7ff, 52'b0};
				else if (s_exp == '0)
					result = {opa[31], 63'b0}; // single subnormals flush to zero
				else
					result = {opa[31], d_exp, s_frac, 29'b0};
			end
			fpu_misc_pkg::OP_CVT_S_D:
			begin
				result[63:32] = fpu_misc_pkg::NAN_BOX;
				if (cls_a.snan || cls_a.qnan)
				begin
					result[31:0]  = fpu_misc_pkg::CANON_NAN_S;
					flags.invalid = cls_a.snan;
				end
				else if (cls_a.inf)
					result[31:0] = {opa[63], 8'hff, 23'b0};
				else if (cls_a.zero)
					result[31:0] = {opa[63], 31'b0};
				else if (cls_a.subnormal || sgl_exp <= 13'sd0)
				begin
					result[31:0]    = {opa[63], 31'b0}; // too small for a single
					flags.underflow = 1'b1;
					flags.inexact   = 1'b1;
				end
				else if (sgl_exp >= 13'sd255)
				begin
					result[31:0]   = {opa[63], 8'hff, 23'b0};
					flags.overflow = 1'b1;
					flags.inexact  = 1'b1;
				end
				else
				begin
					result[31:0]  = {opa[63], sgl_exp[7:0], frac_rnd[22:0]};
					flags.inexact = |opa[28:0]; // dropped fraction bits
				end
			end
			default: ;
		endcase
	end

endmodule

// File: logic/fp_stage_if.sv
`timescale 1ns/10ps
// stage 1 to stage 2 link of the misc FPU
// one operation, both operands and their classes, valid/ready

interface fp_stage_if;

	logic                    valid;
	logic                    ready;
	fpu_misc_pkg::fp_op_e    op;
	logic [63:0]             opa;
	logic [63:0]             opb;
	fpu_misc_pkg::fp_class_t cls_a; // class of opa as a double
	fpu_misc_pkg::fp_class_t cls_b;

	modport producer (
		output valid,
		output op,
		output opa,
		output opb,
		output cls_a,
		output cls_b,
		input  ready
	);

	modport consumer (
		input  valid,
		input  op,
		input  opa,
		input  opb,
		input  cls_a,
		input  cls_b,
		output ready
	);

endinterface

// File: logic/fp_unpack.sv
`timescale 1ns/10ps
// stage 1 of the misc FPU pipeline
// input handshake, operation registers, double operand classification

module fp_unpack (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  fpu_misc_pkg::fp_op_e op,
	input  logic [63:0]          opa,
	input  logic [63:0]          opb,
	fp_stage_if.producer         stage
);

	logic                    take; // input handshake fires this cycle
	fpu_misc_pkg::fp_class_t cls_a_in;
	fpu_misc_pkg::fp_class_t cls_b_in;

	// sort a double into exactly one class
	function automatic fpu_misc_pkg::fp_class_t classify(input logic [63:0] x);
		fpu_misc_pkg::fp_class_t c;
		logic exp_max;
		logic exp_zero;
		logic frac_zero;
		exp_max   = &x[fpu_misc_pkg::FRAC_W +: fpu_misc_pkg::EXP_W];
		exp_zero  = ~|x[fpu_misc_pkg::FRAC_W +: fpu_misc_pkg::EXP_W];
		frac_zero = ~|x[fpu_misc_pkg::FRAC_W-1:0];
		c.sign      = x[63];
		c.zero      = exp_zero && frac_zero;
		c.subnormal = exp_zero && !frac_zero;
		c.normal    = !exp_zero && !exp_max;
		c.inf       = exp_max && frac_zero;
		// quiet bit is the top fraction bit
		c.snan      = exp_max && !frac_zero && !x[fpu_misc_pkg::FRAC_W-1];
		c.qnan      = exp_max && x[fpu_misc_pkg::FRAC_W-1];
		return c;
	endfunction

	// free slot, or the held item leaves this cycle
	assign in_ready = !stage.valid || stage.ready;
	assign take     = in_valid && in_ready;

	assign cls_a_in = classify(opa);
	assign cls_b_in = classify(opb);

	always_ff @(posedge clk)
	begin
		if (rst)
			stage.valid <= 1'b0;
		else if (in_ready)
			stage.valid <= in_valid;
	end

	// payload only
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			stage.op    <= op;
			stage.opa   <= opa;
			stage.opb   <= opb;
			stage.cls_a <= cls_a_in;
			stage.cls_b <= cls_b_in;
		end
	end

	// a stalled item stays put until stage 2 takes it
	payload_hold: assert property (@(posedge clk) disable iff (rst)
		stage.valid && !stage.ready |=> stage.valid
			&& $stable({stage.op, stage.opa, stage.opb, stage.cls_a, stage.cls_b}));

endmodule

// File: logic/fpu_misc_pkg.sv
// shared definitions for the misc double FPU
// field widths, format constants, opcode and fclass enums
// operand class and exception flag structs

package fpu_misc_pkg;

	//////////////////////////////
	// formats
	//////////////////////////////

	localparam int EXP_W      = 11; // double exponent
	localparam int FRAC_W     = 52; // double fraction
	localparam int SGL_EXP_W  = 8;
	localparam int SGL_FRAC_W = 23;

	localparam int BIAS_DIFF = 896; // 1023 - 127

	localparam logic [63:0] CANON_NAN_D = 64'h7ff8000000000000;
	localparam logic [31:0] CANON_NAN_S = 32'h7fc00000;
	localparam logic [31:0] NAN_BOX     = 32'hffffffff; // upper half of a single result

	//////////////////////////////
	// opcodes
	//////////////////////////////

	typedef enum logic [3:0] {
		OP_SGNJ    = 4'd0,
		OP_SGNJN   = 4'd1,
		OP_SGNJX   = 4'd2,
		OP_CLASS   = 4'd3,
		OP_FLE     = 4'd4,
		OP_FLT     = 4'd5,
		OP_FEQ     = 4'd6,
		OP_FMIN    = 4'd7,
		OP_FMAX    = 4'd8,
		OP_CVT_S_D = 4'd9,  // double to single
		OP_CVT_D_S = 4'd10  // single to double
	} fp_op_e;

	// one-hot description of a double operand, plus its sign
	typedef struct packed {
		logic sign;
		logic zero;
		logic subnormal;
		logic normal;
		logic inf;
		logic snan;
		logic qnan;
	} fp_class_t;

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} fp_flags_t;

	// fclass result bit positions, RISC-V order
	typedef enum logic [3:0] {
		CLS_NEG_INF  = 4'd0,
		CLS_NEG_NORM = 4'd1,
		CLS_NEG_SUB  = 4'd2,
		CLS_NEG_ZERO = 4'd3,
		CLS_POS_ZERO = 4'd4,
		CLS_POS_SUB  = 4'd5,
		CLS_POS_NORM = 4'd6,
		CLS_POS_INF  = 4'd7,
		CLS_SNAN     = 4'd8,
		CLS_QNAN     = 4'd9
	} class_bit_e;

endpackage

// File: logic/fpu_misc_top.sv
`timescale 1ns/10ps
// top level of the misc double FPU
// two stage pipeline with valid/ready on both sides

module fpu_misc_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  fpu_misc_pkg::fp_op_e    op,
	input  logic [63:0]             opa,
	input  logic [63:0]             opb,
	output logic                    out_valid,
	input  logic                    out_ready,
	output logic [63:0]             result,
	output fpu_misc_pkg::fp_flags_t flags
);

	fp_stage_if i_stage ();

	// stage 1 registers and classifies
	fp_unpack i_unpack (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.op       (op),
		.opa      (opa),
		.opb      (opb),
		.stage    (i_stage.producer)
	);

	// stage 2 selects and registers the result
	fp_execute i_execute (
		.clk       (clk),
		.rst       (rst),
		.stage     (i_stage.consumer),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result),
		.flags     (flags)
	);

endmodule

// File: include/fpu_ref.svh
// reference model of the misc FPU for the testbench
// NaN tests, total order key, fclass index, expected result and flags

`ifndef FPU_REF_SVH
`define FPU_REF_SVH

function automatic logic is_nan(input logic [63:0] x);
	return (x[62:52] == 11'h7ff) && (x[51:0] != '0);
endfunction

function automatic logic is_snan(input logic [63:0] x);
	return is_nan(x) && !x[51];
endfunction

// unsigned key that sorts doubles, -0 just below +0
function automatic logic [63:0] order_key(input logic [63:0] x);
	return x[63] ? ~x : {1'b1, x[62:0]};
endfunction

function automatic int class_index(input logic [63:0] x);
	logic e_max;
	logic e_zero;
	logic f_zero;
	e_max  = &x[62:52];
	e_zero = x[62:52] == '0;
	f_zero = x[51:0] == '0;
	if (e_max && !f_zero)
		return x[51] ? 9 : 8;
	if (e_max)
		return x[63] ? 0 : 7;
	if (e_zero && f_zero)
		return x[63] ? 3 : 4;
	if (e_zero)
		return x[63] ? 2 : 5;
	return x[63] ? 1 : 6;
endfunction

function automatic void expected_op(input fpu_misc_pkg::fp_op_e op, input logic [63:0] a,
		input logic [63:0] b, output logic [63:0] res, output fpu_misc_pkg::fp_flags_t fl);
	logic nan_a;
	logic nan_b;
	logic zz;
	logic lt;
	logic eq;
	int   e;
	int   se;
	int   m;
	nan_a = is_nan(a);
	nan_b = is_nan(b);
	zz    = (a[62:0] == '0) && (b[62:0] == '0);
	lt    = (order_key(a) < order_key(b)) && !zz;
	eq    = (a == b) || zz;
	res   = '0;
	fl    = '0;
	case (op)
		fpu_misc_pkg::OP_SGNJ:  res = {b[63], a[62:0]};
		fpu_misc_pkg::OP_SGNJN: res = {~b[63], a[62:0]};
		fpu_misc_pkg::OP_SGNJX: res = {a[63] ^ b[63], a[62:0]};
		fpu_misc_pkg::OP_CLASS: res[class_index(a)] = 1'b1;
		fpu_misc_pkg::OP_FLE:
		begin
			res[0]     = !nan_a && !nan_b && (lt || eq);
			fl.invalid = nan_a || nan_b;
		end
		fpu_misc_pkg::OP_FLT:
		begin
			res[0]     = !nan_a && !nan_b && lt;
			fl.invalid = nan_a || nan_b;
		end
		fpu_misc_pkg::OP_FEQ:
		begin
			res[0]     = !nan_a && !nan_b && eq;
			fl.invalid = is_snan(a) || is_snan(b);
		end
		fpu_misc_pkg::OP_FMIN,
		fpu_misc_pkg::OP_FMAX:
		begin
			fl.invalid = is_snan(a) || is_snan(b);
			if (nan_a && nan_b)
				res = fpu_misc_pkg::CANON_NAN_D;
			else if (nan_a || nan_b)
				res = nan_a ? b : a;
			else
				res = ((order_key(a) < order_key(b)) == (op == fpu_misc_pkg::OP_FMIN)) ? a : b;
		end
		fpu_misc_pkg::OP_CVT_D_S:
		begin
			e = int'(a[30:23]);
			if (e == 255 && a[22:0] != '0)
			begin
				res        = fpu_misc_pkg::CANON_NAN_D;
				fl.invalid = !a[22];
			end
			else if (e == 255)
				res = {a[31], 11'h7ff, 52'b0};
			else if (e == 0)
				res = {a[31], 63'b0};
			else
				res = {a[31], 11'(e + 896), a[22:0], 29'b0};
		end
		fpu_misc_pkg::OP_CVT_S_D:
		begin
			res[63:32] = fpu_misc_pkg::NAN_BOX;
			e  = int'(a[62:52]);
			m  = int'(a[51:29]) + int'(a[28]);
			se = e - 896;
			if (m == (1 << 23))
			begin
				m  = 0;
				se = se + 1;
			end
			if (nan_a)
			begin
				res[31:0]  = fpu_misc_pkg::CANON_NAN_S;
				fl.invalid = is_snan(a);
			end
			else if (e == 2047)
				res[31:0] = {a[63], 8'hff, 23'b0};
			else if (e == 0)
			begin
				res[31]      = a[63];
				fl.underflow = a[51:0] != '0;
				fl.inexact   = a[51:0] != '0;
			end
			else if (se >= 255)
			begin
				res[31:0]   = {a[63], 8'hff, 23'b0};
				fl.overflow = 1'b1;
				fl.inexact  = 1'b1;
			end
			else if (se <= 0)
			begin
				res[31]      = a[63];
				fl.underflow = 1'b1;
				fl.inexact   = 1'b1;
			end
			else
			begin
				res[31:0]  = {a[63], 8'(se), 23'(m)};
				fl.inexact = a[28:0] != '0;
			end
		end
		default: ;
	endcase
endfunction

`endif

// File: sim/tb_fpu_misc.sv
`timescale 1ns/10ps
// testbench for the misc double FPU
// directed and random stimulus, expected value queue, result and flag checks

module tb_fpu_misc #(
	parameter int SEED    = 32'h5961,
	parameter int TIMEOUT = 200 // cycles allowed for any single wait
);

	`include "fpu_ref.svh"

	logic                    clk;
	logic                    rst;
	logic                    in_valid;
	logic                    in_ready;
	fpu_misc_pkg::fp_op_e    op;
	logic [63:0]             opa;
	logic [63:0]             opb;
	logic                    out_valid;
	logic                    out_ready;
	logic [63:0]             result;
	fpu_misc_pkg::fp_flags_t flags;

	integer                  seed;
	logic                    bp_random; // out_ready toggles at random when set
	string                   test_name;
	logic [63:0]             exp_res_q[$];
	fpu_misc_pkg::fp_flags_t exp_flag_q[$];
	string                   name_q[$];

	localparam logic [63:0] CLASS_VALS [10] = '{
		64'hfff0000000000000, 64'hbff0000000000000, 64'h800fffffffffffff,
		64'h8000000000000000, 64'h0000000000000000, 64'h0000000000000001,
		64'h3ff0000000000000, 64'h7ff0000000000000, 64'h7ff0000000000001,
		64'h7ff8000000000000
	};

	// pairs that hit the NaN and signed zero rules
	localparam logic [63:0] PAIR_A [9] = '{
		64'h0000000000000000, 64'h8000000000000000, 64'h7ff8000000000000,
		64'h3ff0000000000000, 64'h7ff8000000000000, 64'h7ff4000000000000,
		64'h3ff0000000000000, 64'hc000000000000000, 64'hfff8000000000001
	};
	localparam logic [63:0] PAIR_B [9] = '{
		64'h8000000000000000, 64'h0000000000000000, 64'h3ff0000000000000,
		64'h7ff4000000000000, 64'h7ff4000000000000, 64'h7ff4000000000000,
		64'h3ff0000000000000, 64'hbff0000000000000, 64'h7ff8000000000000
	};

	localparam logic [63:0] S_D_VALS [14] = '{
		64'h3ff0000000000000, 64'hc00921fb54442d18, 64'h3ffffffff0000000, // last one carries
		64'h47f0000000000000, 64'h47efffffffffffff, 64'h3800000000000000,
		64'h3810000000000000, 64'h000fffffffffffff, 64'h8000000000000001,
		64'h7ff8000000000000, 64'h7ff0000000000001, 64'hfff0000000000000,
		64'h8000000000000000, 64'h3ff0000010000001
	};

	localparam logic [31:0] D_S_VALS [12] = '{
		32'h3f800000, 32'hc0490fdb, 32'h00000001, 32'h80400000,
		32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7f800001,
		32'h7fa00000, 32'h00000000, 32'h80000000, 32'h7f7fffff
	};

	fpu_misc_top i_fpu_misc_top (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.op        (op),
		.opa       (opa),
		.opb       (opb),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result),
		.flags     (flags)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	//////////////////////////////
	// failure and compare tasks
	//////////////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic check_result(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		if (act_v !== exp_v)
			report_failure($sformatf("mismatch %s result: expected %h actual %h",
				name, exp_v, act_v));
	endtask

	task automatic check_flags(input string name, input fpu_misc_pkg::fp_flags_t exp_v,
			input fpu_misc_pkg::fp_flags_t act_v);
		if (act_v !== exp_v)
			report_failure($sformatf("mismatch %s flags: expected %b actual %b",
				name, exp_v, act_v));
	endtask

	//////////////////////////////
	// random values
	//////////////////////////////

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	// mostly special values and close magnitudes
	function automatic logic [63:0] pick_operand();
		logic [63:0] x;
		logic [31:0] sel;
		x   = rand64();
		sel = $random(seed);
		case (sel[3:0])
			4'd0:       x = {x[63], 63'b0};
			4'd1:       x = {x[63], 11'h7ff, 52'b0};
			4'd2:       x = {x[63], 11'h7ff, 1'b1, x[50:0]};        // quiet NaN
			4'd3:       x = {x[63], 11'h7ff, 1'b0, x[50:1], 1'b1};  // signalling NaN
			4'd4:       x = {x[63], 11'h000, x[51:0]};
			4'd5, 4'd6: x[62:55] = 8'h7f; // exponent near 1.0
			default: ;
		endcase
		return x;
	endfunction

	function automatic fpu_misc_pkg::fp_op_e random_op();
		logic [31:0] r;
		r = $random(seed);
		r = r % 11;
		return fpu_misc_pkg::fp_op_e'(r[3:0]);
	endfunction

	//////////////////////////////
	// driver
	//////////////////////////////

	// holds the operation until accepted, in_valid stays high afterwards
	task automatic send_op(input string name, input fpu_misc_pkg::fp_op_e op_v,
			input logic [63:0] a, input logic [63:0] b, input logic must_take);
		int waited;
		waited = 0;
		@(negedge clk);
		test_name = name;
		in_valid  = 1'b1;
		op        = op_v;
		opa       = a;
		opb       = b;
		@(posedge clk);
		while (!in_ready)
		begin
			if (must_take)
				report_failure("in_ready was low in a back-to-back stream with out_ready high");
			else if (waited >= TIMEOUT)
				report_failure("timeout waiting for in_ready to accept an operation");
			else
			begin
				waited++;
				@(posedge clk);
			end
		end
	endtask

	task automatic drain(input string what);
		int waited;
		waited = 0;
		@(negedge clk);
		in_valid = 1'b0;
		while (exp_res_q.size() != 0)
		begin
			if (waited >= TIMEOUT)
				report_failure({"timeout waiting for results to drain after ", what});
			else
			begin
				waited++;
				@(negedge clk);
			end
		end
	endtask

	// out_ready from its own seed so the stimulus stays repeatable
	initial
	begin : ready_drive
		integer      bp_seed;
		logic [31:0] r;
		bp_seed   = SEED + 1;
		out_ready = 1'b1;
		forever
		begin
			@(negedge clk);
			r         = $random(bp_seed);
			out_ready = bp_random ? r[0] : 1'b1;
		end
	end

	// expected values are computed when the input handshake fires
	always @(posedge clk)
	begin : accept_mon
		logic [63:0]             exp_r;
		fpu_misc_pkg::fp_flags_t exp_f;
		if (!rst && in_valid && in_ready)
		begin
			expected_op(op, opa, opb, exp_r, exp_f);
			exp_res_q.push_back(exp_r);
			exp_flag_q.push_back(exp_f);
			name_q.push_back(test_name);
		end
	end

	always @(posedge clk)
	begin : check_out
		if (!rst && out_valid && out_ready)
		begin
			if (exp_res_q.size() == 0)
				report_failure("a result came out with no operation outstanding");
			else
			begin
				check_result(name_q[0], exp_res_q[0], result);
				check_flags(name_q[0], exp_flag_q[0], flags);
				exp_res_q.delete(0);
				exp_flag_q.delete(0);
				name_q.delete(0);
			end
		end
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial
	begin : main
		logic [63:0] a;
		logic [63:0] b;
		logic [31:0] sel;
		seed       = SEED;
		rst        = 1'b1;
		in_valid   = 1'b0;
		op         = fpu_misc_pkg::OP_SGNJ;
		opa        = '0;
		opb        = '0;
		bp_random  = 1'b0;
		test_name  = "reset";
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		if (out_valid !== 1'b0 || in_ready !== 1'b1)
			report_failure("out_valid or in_ready has the wrong value after reset");
		check_flags("reset", '0, flags);

		for (int i = 0; i < 40; i++)
		begin
			sel = $random(seed);
			a   = pick_operand();
			b   = pick_operand();
			send_op("sign_inject", fpu_misc_pkg::fp_op_e'(4'(sel % 3)), a, b, 1'b0);
		end
		drain("sign injection");

		for (int i = 0; i < 10; i++)
			send_op("fclass", fpu_misc_pkg::OP_CLASS, CLASS_VALS[i], rand64(), 1'b0);
		drain("fclass");

		for (int k = 4; k <= 8; k++)
			for (int i = 0; i < 9; i++)
				send_op("compare_directed", fpu_misc_pkg::fp_op_e'(4'(k)),
					PAIR_A[i], PAIR_B[i], 1'b0);
		for (int i = 0; i < 120; i++)
		begin
			sel = $random(seed);
			a   = pick_operand();
			b   = sel[8] ? a : pick_operand(); // equal operands half the time
			send_op("compare_random", fpu_misc_pkg::fp_op_e'(4'd4 + 4'(sel % 5)), a, b, 1'b0);
		end
		drain("compares");

		for (int i = 0; i < 14; i++)
			send_op("cvt_s_d", fpu_misc_pkg::OP_CVT_S_D, S_D_VALS[i], rand64(), 1'b0);
		for (int i = 0; i < 12; i++)
			send_op("cvt_d_s", fpu_misc_pkg::OP_CVT_D_S,
				{fpu_misc_pkg::NAN_BOX, D_S_VALS[i]}, rand64(), 1'b0);
		drain("conversions");

		// random back-pressure on a stream of mixed operations
		bp_random = 1'b1;
		for (int i = 0; i < 150; i++)
		begin
			a = pick_operand();
			b = pick_operand();
			send_op("backpressure", random_op(), a, b, 1'b0);
		end
		bp_random = 1'b0;
		drain("back-pressure stream");

		for (int i = 0; i < 40; i++)
		begin
			a = pick_operand();
			b = pick_operand();
			send_op("throughput", random_op(), a, b, 1'b1);
		end
		drain("throughput stream");

		// nothing is left in flight once every expected result was seen
		if (out_valid !== 1'b0)
			report_failure("out_valid stayed high after every expected result was checked");
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// File: src.f
+incdir+include
logic/fpu_misc_pkg.sv
logic/fp_stage_if.sv
logic/fp_unpack.sv
logic/fp_compare.sv
logic/fp_format.sv
logic/fp_execute.sv
logic/fpu_misc_top.sv
sim/tb_fpu_misc.sv
